// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f vlog.f --top-module tb_ma_stage -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q '^TESTS PASSED$' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: src/branch_unit.sv
/* Condition outcome arrives in cond_val_i bit 0; jumps carry the target there instead.
   Only the taken direction is checked against the prediction. */

module branch_unit (
    input  logic                    active_i,   // BRU instruction in MA
    input  ma_pkg::f_part_t         f_i,
    input  logic [ma_pkg::XLEN-1:0] cond_val_i, // Condition bit or jump target
    input  logic                    pred_i,     // Predicted taken
    input  logic [ma_pkg::XLEN-1:0] tadd_i,     // Branch target from EX
    output logic                    taken_o,
    output logic [ma_pkg::XLEN-1:0] target_o,
    output logic                    redirect_o  // Misprediction
);

    logic is_branch;

    assign is_branch = (f_i == ma_pkg::F_BRANCH);

    // Jumps always taken
    assign taken_o = active_i & (is_branch ? cond_val_i[0] : 1'b1);

    // Jump target has its lowest bit cleared
    assign target_o = is_branch ? tadd_i : {cond_val_i[ma_pkg::XLEN-1:1], 1'b0};

    assign redirect_o = active_i & (taken_o ^ pred_i);

endmodule

// File: src/lsu_decoder.sv
/* Little-endian lanes. A misaligned offset is not checked, the word is just shifted. */

module lsu_decoder (
    input  logic [ma_pkg::XLEN-1:0] data_i,     // Bus word
    input  ma_pkg::ld_info_t        ld_info_i,  // Function and byte offset
    output logic [ma_pkg::XLEN-1:0] data_o      // Register-file value
);

    logic [ma_pkg::XLEN-1:0] shifted;

    // Bring the addressed byte to lane 0
    assign shifted = data_i >> {ld_info_i.offset, 3'b000};

    always_comb begin
        case (ld_info_i.f)
            ma_pkg::F_LB:  data_o = {{(ma_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
            ma_pkg::F_LBU: data_o = {{(ma_pkg::XLEN-8){1'b0}}, shifted[7:0]};
            ma_pkg::F_LH:  data_o = {{(ma_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
            ma_pkg::F_LHU: data_o = {{(ma_pkg::XLEN-16){1'b0}}, shifted[15:0]};
            ma_pkg::F_LW:  data_o = shifted;
            default:       data_o = shifted;        // Unknown code treated as word
        endcase
    end

endmodule

// File: src/ma_pkg.sv
/* Shared widths, control types and function codes of the MA stage.
   Function codes follow RISC-V funct3 for loads; BRU codes are local to this core. */

package ma_pkg;

    // Datapath and address width
    parameter int XLEN = 32;

    // Register-file address
    typedef logic [4:0] rf_add_t;

    // Instruction function field, funct3 for loads
    typedef logic [2:0] f_part_t;

    // Instruction control, all zero means empty slot
    typedef struct packed {
        logic reg_dest;     // Result goes to the register file
        logic rvc;          // Compressed instruction, 2-byte step
        logic unit_alu;     // Executed by the ALU
        logic unit_lsu;     // Load or store through the LSU
        logic unit_bru;     // Branch or jump
    } ictrl_t;

    // Misconduct carried along with the instruction
    typedef enum logic [1:0] {
        IMISCON_FREE = 2'b00,   // Clean instruction
        IMISCON_DSCR = 2'b01,   // Discarded earlier, restart at this point
        IMISCON_FERR = 2'b10    // Fetch bus error, restart at this point
    } imiscon_t;

    // Load info kept for the WB half
    typedef struct packed {
        f_part_t    f;          // Load function
        logic [1:0] offset;     // Byte offset inside the word
    } ld_info_t;

    // Load functions
    parameter f_part_t F_LB  = 3'b000;
    parameter f_part_t F_LH  = 3'b001;
    parameter f_part_t F_LW  = 3'b010;
    parameter f_part_t F_LBU = 3'b100;
    parameter f_part_t F_LHU = 3'b101;

    // BRU conditional branch; every other BRU code is a jump
    parameter f_part_t F_BRANCH = 3'b001;

    // Address increments
    parameter logic [2:0] PC_INCR_STD = 3'd4;
    parameter logic [2:0] PC_INCR_RVC = 3'd2;

endpackage

// File: src/ma_restart_fsm.sv
/* INIT lasts one cycle after reset release; LOCKED is left only by reset.
   A restart always wins over a stall. */

module ma_restart_fsm #(
    parameter int RST_MAX = 4
) (
    input  logic             s_clk_i,
    input  logic             arst_n_i,
    input  ma_pkg::ictrl_t   ictrl_i,           // Instruction in MA
    input  ma_pkg::imiscon_t imiscon_i,
    input  logic             lsu_ready_i,
    input  logic             lsu_busy_i,
    input  logic             lsu_hresp_i,
    input  logic             redirect_i,        // Misprediction from the BRU
    output logic             init_o,
    output logic             restart_o,
    output logic             advance_o,
    output logic             stall_o,
    output logic             flush_o,
    output logic             pred_disable_o,
    output logic             hrdmax_rst_o
);

    typedef enum logic [1:0] {
        ST_INIT,        // Restart to boot address
        ST_RUN,         // Normal flow
        ST_RECOVER,     // Restarted, nothing retired yet
        ST_LOCKED       // Degraded mode
    } state_t;

    state_t state, state_nxt;
    logic   prior_rst;      // Restart requested before MA
    logic   trans_rst;      // Bus error on an intended transfer
    logic   berr_rst;       // Bus error with no LSU op in MA
    logic   active;
    logic   at_max;

    assign init_o    = (state == ST_INIT);
    assign active    = (ictrl_i != '0);                          // Slot holds an instruction
    assign prior_rst = (imiscon_i == ma_pkg::IMISCON_DSCR);
    assign trans_rst = (imiscon_i == ma_pkg::IMISCON_FERR) | (lsu_hresp_i & ictrl_i.unit_lsu);
    assign berr_rst  = lsu_hresp_i & ~ictrl_i.unit_lsu;
    assign restart_o = prior_rst | trans_rst | berr_rst | init_o;

    // Extended data-bus transfer, masked by restart
    assign stall_o   = ictrl_i.unit_lsu & (~lsu_ready_i | lsu_busy_i) & ~restart_o;
    assign advance_o = active & ~stall_o & ~restart_o;
    assign flush_o   = restart_o | (advance_o & redirect_i);

    assign hrdmax_rst_o   = (state == ST_LOCKED);
    assign pred_disable_o = (state == ST_LOCKED);   // No prediction once degraded

    // Consecutive restarts, cleared by retirement
    restart_counter #(
        .RST_MAX(RST_MAX)
    ) u_restart_counter (
        .s_clk_i (s_clk_i),
        .arst_n_i(arst_n_i),
        .inc_i   (restart_o & ~init_o),  // Boot restart not counted
        .clr_i   (advance_o),
        .at_max_o(at_max)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT:    state_nxt = ST_RUN;
            ST_RUN: begin
                if (at_max)         state_nxt = ST_LOCKED;
                else if (restart_o) state_nxt = ST_RECOVER;
            end
            ST_RECOVER: begin
                if (at_max)         state_nxt = ST_LOCKED;
                else if (advance_o) state_nxt = ST_RUN;      // Something retired
            end
            default:    state_nxt = ST_LOCKED;               // Held until reset
        endcase
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) state <= ST_INIT;
        else           state <= state_nxt;
    end

endmodule

// File: src/ma_stage.sv
/* Memory-access stage, single datapath. Stall, flush and LSU status are plain levels.
   RST_MAX consecutive restarts without retirement lock the stage in degraded mode. */

module ma_stage #(
    parameter int RST_MAX = 4                           // Restarts before degraded mode
) (
    input  logic                     s_clk_i,           // Clock
    input  logic                     arst_n_i,          // Async reset, active low
    input  logic [ma_pkg::XLEN-1:0]  boot_addr_i,       // Boot address

    // Instruction record from EX
    input  ma_pkg::ictrl_t           exma_ictrl_i,      // Instruction control
    input  ma_pkg::imiscon_t         exma_imiscon_i,    // Misconduct
    input  ma_pkg::f_part_t          exma_f_i,          // Function
    input  ma_pkg::rf_add_t          exma_rd_i,         // Destination register
    input  logic [ma_pkg::XLEN-1:0]  exma_val_i,        // EX result, address or jump target
    input  logic                     exma_pred_i,       // Predicted taken
    input  logic [ma_pkg::XLEN-1:0]  exma_tadd_i,       // Conditional branch target

    // LSU
    input  logic [ma_pkg::XLEN-1:0]  lsu_data_i,        // Read data
    input  logic                     lsu_ready_i,       // Transfer done
    input  logic                     lsu_busy_i,        // Cannot take a new request
    input  logic                     lsu_hresp_i,       // Data bus error

    // Pipeline control
    output logic                     stall_o,           // Stall lower stages
    output logic                     flush_o,           // Flush lower stages
    output logic [ma_pkg::XLEN-1:0]  toc_addr_o,        // Transfer-of-control address

    // MA/WB register
    output ma_pkg::ictrl_t           mawb_ictrl_o,
    output ma_pkg::rf_add_t          mawb_rd_o,
    output logic [ma_pkg::XLEN-1:0]  mawb_val_o,

    output logic                     pred_disable_o,    // Disable prediction
    output logic                     hrdmax_rst_o       // Restart limit reached
);

    logic                    init;          // First cycle after reset
    logic                    restart;       // Pipeline restart this cycle
    logic                    advance;       // Instruction leaves MA
    logic                    taken;
    logic                    redirect;      // Taken differs from prediction
    logic [ma_pkg::XLEN-1:0] target;
    logic [ma_pkg::XLEN-1:0] next_pc;       // Link value

    // Restart causes, stall, flush and degraded mode
    ma_restart_fsm #(
        .RST_MAX(RST_MAX)
    ) u_restart_fsm (
        .s_clk_i       (s_clk_i),
        .arst_n_i      (arst_n_i),
        .ictrl_i       (exma_ictrl_i),
        .imiscon_i     (exma_imiscon_i),
        .lsu_ready_i   (lsu_ready_i),
        .lsu_busy_i    (lsu_busy_i),
        .lsu_hresp_i   (lsu_hresp_i),
        .redirect_i    (redirect),
        .init_o        (init),
        .restart_o     (restart),
        .advance_o     (advance),
        .stall_o       (stall_o),
        .flush_o       (flush_o),
        .pred_disable_o(pred_disable_o),
        .hrdmax_rst_o  (hrdmax_rst_o)
    );

    branch_unit u_branch_unit (
        .active_i  (exma_ictrl_i.unit_bru),
        .f_i       (exma_f_i),
        .cond_val_i(exma_val_i),
        .pred_i    (exma_pred_i),
        .tadd_i    (exma_tadd_i),
        .taken_o   (taken),
        .target_o  (target),
        .redirect_o(redirect)
    );

    reset_point u_reset_point (
        .s_clk_i    (s_clk_i),
        .arst_n_i   (arst_n_i),
        .boot_addr_i(boot_addr_i),
        .init_i     (init),
        .restart_i  (restart),
        .advance_i  (advance),
        .rvc_i      (exma_ictrl_i.rvc),
        .taken_i    (taken),
        .target_i   (target),
        .toc_addr_o (toc_addr_o),
        .next_pc_o  (next_pc)
    );

    mawb_stage u_mawb_stage (
        .s_clk_i     (s_clk_i),
        .arst_n_i    (arst_n_i),
        .advance_i   (advance),
        .ictrl_i     (exma_ictrl_i),
        .f_i         (exma_f_i),
        .rd_i        (exma_rd_i),
        .ex_val_i    (exma_val_i),
        .lsu_data_i  (lsu_data_i),
        .next_pc_i   (next_pc),
        .mawb_ictrl_o(mawb_ictrl_o),
        .mawb_rd_o   (mawb_rd_o),
        .mawb_val_o  (mawb_val_o)
    );

endmodule

// File: src/mawb_stage.sv
/* MA/WB pipeline register. Only ictrl has reset and is zeroed in cycles without advance;
   value, rd and load info keep their last advanced contents. */

module mawb_stage (
    input  logic                    s_clk_i,
    input  logic                    arst_n_i,
    input  logic                    advance_i,      // Instruction leaves MA
    input  ma_pkg::ictrl_t          ictrl_i,
    input  ma_pkg::f_part_t         f_i,
    input  ma_pkg::rf_add_t         rd_i,
    input  logic [ma_pkg::XLEN-1:0] ex_val_i,       // EX result or load address
    input  logic [ma_pkg::XLEN-1:0] lsu_data_i,     // Raw bus word
    input  logic [ma_pkg::XLEN-1:0] next_pc_i,      // Link address
    output ma_pkg::ictrl_t          mawb_ictrl_o,
    output ma_pkg::rf_add_t         mawb_rd_o,
    output logic [ma_pkg::XLEN-1:0] mawb_val_o
);

    logic [ma_pkg::XLEN-1:0] write_val;
    logic [ma_pkg::XLEN-1:0] val_q;
    logic [ma_pkg::XLEN-1:0] ld_data;
    ma_pkg::ld_info_t        ldi_d;
    ma_pkg::ld_info_t        ldi_q;

    // Result of the MA half
    always_comb begin
        if (ictrl_i.unit_lsu)      write_val = lsu_data_i;
        else if (ictrl_i.unit_bru) write_val = next_pc_i;
        else                       write_val = ex_val_i;
    end

    assign ldi_d.f      = f_i;
    assign ldi_d.offset = ex_val_i[1:0];    // Byte lane of the access

    // Empty slot unless something advanced
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) mawb_ictrl_o <= '0;
        else           mawb_ictrl_o <= advance_i ? ictrl_i : '0;
    end

    always_ff @(posedge s_clk_i) begin
        if (advance_i) begin
            val_q     <= write_val;
            mawb_rd_o <= rd_i;
            ldi_q     <= ldi_d;
        end
    end

    // WB half, load formatting
    lsu_decoder u_lsu_decoder (
        .data_i   (val_q),
        .ld_info_i(ldi_q),
        .data_o   (ld_data)
    );

    assign mawb_val_o = mawb_ictrl_o.unit_lsu ? ld_data : val_q;

endmodule

// File: src/reset_point.sv
/* Reset point is the address of the instruction in MA.
   It moves only on advance, so it holds through stalls and restarts. */

module reset_point (
    input  logic                    s_clk_i,
    input  logic                    arst_n_i,
    input  logic [ma_pkg::XLEN-1:0] boot_addr_i,
    input  logic                    init_i,      // Restart to boot address
    input  logic                    restart_i,
    input  logic                    advance_i,
    input  logic                    rvc_i,       // Compressed instruction
    input  logic                    taken_i,
    input  logic [ma_pkg::XLEN-1:0] target_i,
    output logic [ma_pkg::XLEN-1:0] toc_addr_o,
    output logic [ma_pkg::XLEN-1:0] next_pc_o    // Sequential address, link value
);

    logic [ma_pkg::XLEN-1:0] rst_point;
    logic [ma_pkg::XLEN-1:0] new_point;
    logic [2:0]              pc_incr;

    assign pc_incr   = rvc_i ? ma_pkg::PC_INCR_RVC : ma_pkg::PC_INCR_STD;
    assign next_pc_o = rst_point + ma_pkg::XLEN'(pc_incr);
    assign new_point = taken_i ? target_i : next_pc_o;     // Where the next instruction lives

    // Boot first, then current point on restart
    always_comb begin
        if (init_i)         toc_addr_o = boot_addr_i;
        else if (restart_i) toc_addr_o = rst_point;
        else                toc_addr_o = new_point;
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rst_point <= '0;
        end else if (init_i) begin
            rst_point <= boot_addr_i;
        end else if (advance_i) begin
            rst_point <= new_point;
        end
    end

endmodule

// File: src/restart_counter.sv
/* Saturates at RST_MAX. Clear wins over increment. */

module restart_counter #(
    parameter int RST_MAX = 4
) (
    input  logic s_clk_i,
    input  logic arst_n_i,
    input  logic inc_i,         // Restart outside INIT
    input  logic clr_i,         // Instruction retired
    output logic at_max_o       // Limit reached
);

    localparam int CW = $clog2(RST_MAX + 1);   // Enough to hold RST_MAX itself

    logic [CW-1:0] cnt;

    assign at_max_o = (cnt == CW'(RST_MAX));

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt <= '0;
        end else if (clr_i) begin
            cnt <= '0;
        end else if (inc_i && !at_max_o) begin
            cnt <= cnt + 1'b1;              // Stop at the limit
        end
    end

endmodule

// File: verif/ma_stage_props.sv
/* Pipeline-control rules bound into every ma_stage instance.
   The boot restart is expected in the first cycle after reset release. */

module ma_stage_props (
    input logic           s_clk_i,
    input logic           arst_n_i,
    input ma_pkg::ictrl_t exma_ictrl_i,
    input logic           stall_o,
    input logic           flush_o,
    input ma_pkg::ictrl_t mawb_ictrl_o,
    input logic           hrdmax_rst_o
);

    int n_fail = 0;

    // Stall only for an LSU transfer and nothing enters MA/WB
    stall_needs_lsu: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        stall_o |-> exma_ictrl_i.unit_lsu ##1 (mawb_ictrl_o == '0))
        else begin
            n_fail++;
            $error("stall_o high without an LSU instruction or with a write to MA/WB");
        end

    // Boot restart in the first cycle after release
    init_flush: assert property (@(posedge s_clk_i) $rose(arst_n_i) |-> flush_o)
        else begin
            n_fail++;
            $error("flush_o low in the first cycle after reset");
        end

    // Degraded mode is left only by reset
    locked_sticky: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        hrdmax_rst_o |=> hrdmax_rst_o)
        else begin
            n_fail++;
            $error("hrdmax_rst_o dropped without reset");
        end

endmodule

bind ma_stage ma_stage_props u_ma_stage_props (
    .s_clk_i     (s_clk_i),
    .arst_n_i    (arst_n_i),
    .exma_ictrl_i(exma_ictrl_i),
    .stall_o     (stall_o),
    .flush_o     (flush_o),
    .mawb_ictrl_o(mawb_ictrl_o),
    .hrdmax_rst_o(hrdmax_rst_o)
);

// File: verif/tb_ma_stage.sv
/* Directed tests of ma_stage with RST_MAX 4 and boot address 0x1000.
   Load words and addresses come from $random with a fixed seed. */

module tb_ma_stage;

    typedef logic [ma_pkg::XLEN-1:0] word_t;

    localparam int RST_MAX     = 4;
    localparam int RESET_CYC   = 5;
    localparam int CYCLE_LIMIT = 2 * (RESET_CYC + 2 + 7 + 13 + 3 + 4 + 12);   // Test lengths, doubled

    // Control patterns {reg_dest, rvc, alu, lsu, bru}
    localparam ma_pkg::ictrl_t IC_ALU     = 5'b10100;
    localparam ma_pkg::ictrl_t IC_ALU_RVC = 5'b11100;
    localparam ma_pkg::ictrl_t IC_LOAD    = 5'b10010;
    localparam ma_pkg::ictrl_t IC_BR      = 5'b00001;
    localparam ma_pkg::ictrl_t IC_JAL     = 5'b10001;

    logic             clk;
    logic             arst_n;
    word_t            boot_addr;
    ma_pkg::ictrl_t   ex_ictrl;
    ma_pkg::imiscon_t ex_imiscon;
    ma_pkg::f_part_t  ex_f;
    ma_pkg::rf_add_t  ex_rd;
    word_t            ex_val;
    logic             ex_pred;
    word_t            ex_tadd;
    word_t            lsu_data;
    logic             lsu_ready;
    logic             lsu_busy;
    logic             lsu_hresp;
    logic             stall;
    logic             flush;
    word_t            toc_addr;
    ma_pkg::ictrl_t   wb_ictrl;
    ma_pkg::rf_add_t  wb_rd;
    word_t            wb_val;
    logic             pred_disable;
    logic             hrdmax_rst;

    word_t            exp_rp;               // Model of the reset point
    int               seed;
    int               n_checks  = 0;
    int               n_errors  = 0;
    int               cycle_cnt = 0;

    ma_stage #(.RST_MAX(RST_MAX)) u_ma_stage (
        .s_clk_i(clk), .arst_n_i(arst_n), .boot_addr_i(boot_addr),
        .exma_ictrl_i(ex_ictrl), .exma_imiscon_i(ex_imiscon), .exma_f_i(ex_f),
        .exma_rd_i(ex_rd), .exma_val_i(ex_val), .exma_pred_i(ex_pred), .exma_tadd_i(ex_tadd),
        .lsu_data_i(lsu_data), .lsu_ready_i(lsu_ready), .lsu_busy_i(lsu_busy),
        .lsu_hresp_i(lsu_hresp), .stall_o(stall), .flush_o(flush), .toc_addr_o(toc_addr),
        .mawb_ictrl_o(wb_ictrl), .mawb_rd_o(wb_rd), .mawb_val_o(wb_val),
        .pred_disable_o(pred_disable), .hrdmax_rst_o(hrdmax_rst)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, test sequence did not finish", cycle_cnt);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_addr(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ictrl(input string name, input ma_pkg::ictrl_t got,
                               input ma_pkg::ictrl_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input ma_pkg::rf_add_t got,
                            input ma_pkg::rf_add_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (n_errors == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, n_errors - errs_before);
    endtask

    // Expected WB value from byte lanes picked one by one
    function automatic word_t load_result(input ma_pkg::f_part_t f, input logic [1:0] off,
                                          input word_t word);
        logic [7:0]  b;
        logic [15:0] h;
        case (off)
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = off[1] ? word[31:16] : word[15:0];
        case (f)
            ma_pkg::F_LB:  load_result = {{24{b[7]}}, b};
            ma_pkg::F_LBU: load_result = {24'h0, b};
            ma_pkg::F_LH:  load_result = {{16{h[15]}}, h};
            ma_pkg::F_LHU: load_result = {16'h0, h};
            default:       load_result = word;
        endcase
    endfunction

    function automatic logic legal_offset(input ma_pkg::f_part_t f, input logic [1:0] off);
        if (f == ma_pkg::F_LW) legal_offset = (off == 2'd0);
        else if (f == ma_pkg::F_LH || f == ma_pkg::F_LHU) legal_offset = ~off[0];
        else legal_offset = 1'b1;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;                                // Drive point after the edge
    endtask

    task automatic drive_instr(input ma_pkg::ictrl_t ic, input ma_pkg::f_part_t f,
                               input ma_pkg::rf_add_t rd, input word_t val,
                               input logic pred, input word_t tadd);
        ex_ictrl   = ic;
        ex_imiscon = ma_pkg::IMISCON_FREE;
        ex_f       = f;
        ex_rd      = rd;
        ex_val     = val;
        ex_pred    = pred;
        ex_tadd    = tadd;
        lsu_ready  = 1'b1;                  // LSU idle and done by default
        lsu_busy   = 1'b0;
        lsu_hresp  = 1'b0;
    endtask

    task automatic idle_cycle();
        drive_instr('0, '0, '0, '0, 1'b0, '0);
        next_cycle();
    endtask

    // One instruction through MA into MA/WB with the model following toc_addr
    task automatic send_and_retire(input ma_pkg::ictrl_t ic, input ma_pkg::f_part_t f,
                                   input ma_pkg::rf_add_t rd, input word_t val, input logic pred,
                                   input word_t tadd, input logic exp_flush,
                                   input word_t exp_toc, input word_t exp_wb);
        drive_instr(ic, f, rd, val, pred, tadd);
        #20;
        check_bit("stall_o", stall, 1'b0);
        check_bit("flush_o", flush, exp_flush);
        check_addr("toc_addr_o", toc_addr, exp_toc);
        next_cycle();
        exp_rp = exp_toc;
        check_ictrl("mawb_ictrl_o", wb_ictrl, ic);
        check_rd("mawb_rd_o", wb_rd, rd);
        check_addr("mawb_val_o", wb_val, exp_wb);
    endtask

    // Restart flushes to the unchanged reset point and writes nothing
    task automatic restart_check(input ma_pkg::ictrl_t ic, input ma_pkg::imiscon_t misc,
                                 input logic hresp);
        drive_instr(ic, ma_pkg::F_LW, 5'd3, exp_rp, 1'b0, '0);
        ex_imiscon = misc;
        lsu_hresp  = hresp;
        lsu_ready  = 1'b0;                  // Pending transfer that a restart must not stall on
        #20;
        check_bit("flush_o", flush, 1'b1);
        check_bit("stall_o", stall, 1'b0);
        check_addr("toc_addr_o", toc_addr, exp_rp);
        next_cycle();
        check_ictrl("mawb_ictrl_o", wb_ictrl, '0);
    endtask

    task automatic init_test();
        int errs;
        errs = n_errors;
        #20;
        check_bit("flush_o", flush, 1'b1);
        check_addr("toc_addr_o", toc_addr, boot_addr);
        check_bit("stall_o", stall, 1'b0);
        check_bit("hrdmax_rst_o", hrdmax_rst, 1'b0);
        check_bit("pred_disable_o", pred_disable, 1'b0);
        check_ictrl("mawb_ictrl_o", wb_ictrl, '0);
        next_cycle();
        exp_rp = boot_addr;                 // Loaded at the INIT edge
        #20;
        check_bit("flush_o", flush, 1'b0);
        check_addr("toc_addr_o", toc_addr, exp_rp + 32'd4);
        next_cycle();
        finish_test("init", errs);
    endtask

    task automatic bru_test();
        word_t link;
        int    errs;
        errs = n_errors;
        send_and_retire(IC_ALU, '0, 5'd5, 32'h1234_5678, 1'b0, '0, 1'b0, exp_rp + 32'd4,
                        32'h1234_5678);
        send_and_retire(IC_ALU_RVC, '0, 5'd6, 32'h0000_abcd, 1'b0, '0, 1'b0, exp_rp + 32'd2,
                        32'h0000_abcd);
        link = exp_rp + 32'd4;              // Taken against a not-taken prediction
        send_and_retire(IC_BR, ma_pkg::F_BRANCH, 5'd0, 32'd1, 1'b0, 32'h0000_4000, 1'b1,
                        32'h0000_4000, link);
        link = exp_rp + 32'd4;              // Jump with code 0 drops bit 0 of the target
        send_and_retire(IC_JAL, 3'd0, 5'd1, 32'h0000_8001, 1'b0, '0, 1'b1,
                        32'h0000_8001 & ~32'd1, link);
        link = exp_rp + 32'd4;
        send_and_retire(IC_BR, ma_pkg::F_BRANCH, 5'd0, 32'd1, 1'b1, 32'h0000_8100, 1'b0,
                        32'h0000_8100, link);
        link = exp_rp + 32'd4;              // Not taken as predicted
        send_and_retire(IC_BR, ma_pkg::F_BRANCH, 5'd0, 32'd0, 1'b0, 32'h0000_9000, 1'b0,
                        link, link);
        idle_cycle();
        check_ictrl("mawb_ictrl_o", wb_ictrl, '0);
        finish_test("alu_bru", errs);
    endtask

    task automatic load_test();
        ma_pkg::f_part_t funcs [5];
        word_t           word;
        word_t           addr;
        logic [1:0]      off;
        int              errs;
        funcs = '{ma_pkg::F_LB, ma_pkg::F_LH, ma_pkg::F_LW, ma_pkg::F_LBU, ma_pkg::F_LHU};
        errs  = n_errors;
        for (int i = 0; i < 5; i++) begin
            for (int o = 0; o < 4; o++) begin
                off = 2'(o);
                if (legal_offset(funcs[i], off)) begin
                    word      = $random(seed);
                    addr      = $random(seed);
                    addr[1:0] = off;
                    lsu_data  = word;
                    send_and_retire(IC_LOAD, funcs[i], 5'(i + 10), addr, 1'b0, '0, 1'b0,
                                    exp_rp + 32'd4, load_result(funcs[i], off, word));
                end
            end
        end
        finish_test("load", errs);
    endtask

    task automatic stall_test();
        word_t word;
        word_t addr;
        int    errs;
        errs      = n_errors;
        word      = $random(seed);
        addr      = $random(seed);
        addr[1:0] = 2'd0;
        lsu_data  = word;
        drive_instr(IC_LOAD, ma_pkg::F_LW, 5'd9, addr, 1'b0, '0);
        lsu_ready = 1'b0;                   // Transfer extended
        #20;
        check_bit("stall_o", stall, 1'b1);
        check_bit("flush_o", flush, 1'b0);
        next_cycle();
        check_ictrl("mawb_ictrl_o", wb_ictrl, '0);
        lsu_ready = 1'b1;
        lsu_busy  = 1'b1;                   // Done but LSU still busy
        #20;
        check_bit("stall_o", stall, 1'b1);
        next_cycle();
        check_ictrl("mawb_ictrl_o", wb_ictrl, '0);
        // Step from the held reset point
        send_and_retire(IC_LOAD, ma_pkg::F_LW, 5'd9, addr, 1'b0, '0, 1'b0, exp_rp + 32'd4, word);
        finish_test("stall", errs);
    endtask

    task automatic restart_test();
        int errs;
        errs = n_errors;
        restart_check(IC_ALU, ma_pkg::IMISCON_DSCR, 1'b0);
        restart_check(IC_ALU, ma_pkg::IMISCON_FERR, 1'b0);
        restart_check(IC_LOAD, ma_pkg::IMISCON_FREE, 1'b1);
        send_and_retire(IC_ALU, '0, 5'd2, 32'h0000_0042, 1'b0, '0, 1'b0, exp_rp + 32'd4,
                        32'h0000_0042);
        check_bit("hrdmax_rst_o", hrdmax_rst, 1'b0);
        finish_test("restart", errs);
    endtask

    task automatic degraded_test();
        int errs;
        errs = n_errors;
        // Bus error with no LSU op in MA
        repeat (RST_MAX - 1) restart_check(IC_ALU, ma_pkg::IMISCON_FREE, 1'b1);
        send_and_retire(IC_ALU, '0, 5'd4, 32'h0bad_0001, 1'b0, '0, 1'b0, exp_rp + 32'd4,
                        32'h0bad_0001);     // Clears the count
        check_bit("hrdmax_rst_o", hrdmax_rst, 1'b0);
        check_bit("pred_disable_o", pred_disable, 1'b0);
        repeat (RST_MAX) restart_check(IC_LOAD, ma_pkg::IMISCON_FREE, 1'b1);
        idle_cycle();
        check_bit("hrdmax_rst_o", hrdmax_rst, 1'b1);
        check_bit("pred_disable_o", pred_disable, 1'b1);
        repeat (2) send_and_retire(IC_ALU, '0, 5'd7, 32'h0000_0777, 1'b0, '0, 1'b0,
                                   exp_rp + 32'd4, 32'h0000_0777);
        restart_check(IC_ALU, ma_pkg::IMISCON_FERR, 1'b0);
        check_bit("hrdmax_rst_o", hrdmax_rst, 1'b1);
        check_bit("pred_disable_o", pred_disable, 1'b1);
        finish_test("degraded", errs);
    endtask

    initial begin
        seed      = 32'hb9df;
        boot_addr = 32'h0000_1000;
        arst_n    = 1'b0;
        lsu_data  = '0;
        exp_rp    = '0;
        drive_instr('0, '0, '0, '0, 1'b0, '0);
        repeat (RESET_CYC) @(posedge clk);
        #10;
        arst_n = 1'b1;
        init_test();
        bru_test();
        load_test();
        stall_test();
        restart_test();
        degraded_test();
        n_errors = n_errors + u_ma_stage.u_ma_stage_props.n_fail;
        $display("summary: %0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
                 u_ma_stage.u_ma_stage_props.n_fail);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/ma_pkg.sv
src/restart_counter.sv
src/branch_unit.sv
src/reset_point.sv
src/lsu_decoder.sv
src/mawb_stage.sv
src/ma_restart_fsm.sv
src/ma_stage.sv
verif/ma_stage_props.sv
verif/tb_ma_stage.sv
